// ==== source/up_alu.sv ====
module up_alu (
   input  up_ctrl_pkg::alu_op_e op,
   input  up_isa_pkg::word_t    a,
   input  up_isa_pkg::word_t    b,
   output up_isa_pkg::word_t    y
);
   import up_ctrl_pkg::*;

   always_comb begin
      case (op)
         alu_add:  y = a + b;
         alu_sub:  y = a - b;
         // only the low byte survives.
         alu_mul:  y = a * b;
         alu_nand: y = ~(a & b);
         alu_xor:  y = a ^ b;
         default:  y = '0;
      endcase
   end

endmodule

// ==== source/up_control.sv ====
module up_control (
   input  logic                clk,
   input  logic                nRst,
   input  logic                regs_eq,
   input  logic                pc_lsb,
   input  up_isa_pkg::word_t   mem_rdata,
   output up_ctrl_pkg::ctrl_t  ctrl
);
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;

   state_e  state;
   opcode_e ir;
   logic    swap_op;
   rsel_t   swap_lo;
   rsel_t   swap_hi;

   // sw01, sw12 and sw23 differ only in the register pair.
   assign swap_op = ir inside {op_sw01, op_sw12, op_sw23};
   assign swap_lo = rsel_t'(ir[1:0]);
   assign swap_hi = swap_lo + 2'd1;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= st_boot0;
         ir    <= op_add;
      end else begin
         case (state)
            st_boot0:  state <= st_boot1;
            st_boot1:  state <= st_boot2;
            st_boot2:  state <= st_boot3;
            st_boot3:  state <= st_boot4;
            st_boot4:  state <= st_fetch;
            st_fetch:  state <= st_decode;
            st_decode: state <= st_exec1;
            st_exec1:  state <= (ir inside {op_add, op_sub, op_mul, op_nand, op_be, op_int}) ?
                                st_fetch : st_exec2;
            st_exec2:  state <= (ir inside {op_popc, op_pop, op_ldw, op_stw, op_ref}) ?
                                st_fetch : st_exec3;
            default:   state <= st_fetch;
         endcase
         // odd nibble address picks the low half.
         if (ctrl.ir_we)
            ir <= pc_lsb ? opcode_e'(mem_rdata[3:0]) : opcode_e'(mem_rdata[7:4]);
      end
   end

   always_comb begin
      ctrl        = '0;
      ctrl.src    = src_zero;
      ctrl.alu_op = alu_op_e'({1'b0, ir[1:0]});
      ctrl.alu_a  = 2'd1;
      ctrl.alu_b  = 2'd2;
      if (swap_op) begin
         ctrl.alu_op = alu_xor;
         ctrl.alu_a  = swap_lo;
         ctrl.alu_b  = swap_hi;
      end
      case (state)
         st_boot0: ctrl.ale = 1'b1;
         st_boot1, st_boot2, st_boot3, st_boot4: begin
            // boot4 loads r3 and points at the first opcode byte.
            ctrl.src         = (state == st_boot4) ? src_fetch_addr : src_boot_addr;
            ctrl.ale         = 1'b1;
            ctrl.rb_we       = 1'b1;
            ctrl.rb_from_mem = 1'b1;
            ctrl.rb_sel      = rsel_t'(state - st_boot1);
         end
         st_fetch: begin
            ctrl.src = src_fetch_addr;
            ctrl.ale = 1'b1;
         end
         st_decode: begin
            ctrl.src   = src_pc_inc;
            ctrl.ir_we = 1'b1;
            ctrl.pc_we = 1'b1;
         end
         st_exec1: begin
            case (ir)
               op_add, op_sub, op_mul, op_nand: begin
                  ctrl.src   = src_alu;
                  ctrl.rb_we = 1'b1;
               end
               op_sw01, op_sw12, op_sw23: begin
                  ctrl.src    = src_alu;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = swap_lo;
               end
               op_be: begin
                  ctrl.src   = src_r3;
                  ctrl.pc_we = regs_eq;
               end
               op_popc, op_pop: begin
                  ctrl.src   = src_sp_inc;
                  ctrl.sp_we = 1'b1;
                  ctrl.ale   = 1'b1;
               end
               op_pushc, op_push: begin
                  ctrl.src = src_sp;
                  ctrl.ale = 1'b1;
               end
               op_ldw, op_stw: begin
                  ctrl.src = src_r3;
                  ctrl.ale = 1'b1;
               end
               op_ref: ctrl.ale = 1'b1;
               default: ;
            endcase
         end
         st_exec2: begin
            case (ir)
               op_sw01, op_sw12, op_sw23: begin
                  ctrl.src    = src_alu;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = swap_hi;
               end
               op_popc: begin
                  ctrl.src   = src_mem;
                  ctrl.pc_we = 1'b1;
               end
               op_pushc, op_push: begin
                  ctrl.src   = src_sp_dec;
                  ctrl.sp_we = 1'b1;
               end
               op_pop, op_ldw, op_ref: begin
                  // ref reloads r0, the others load r2.
                  ctrl.src         = src_mem;
                  ctrl.rb_we       = 1'b1;
                  ctrl.rb_from_mem = 1'b1;
                  ctrl.rb_sel      = (ir == op_ref) ? 2'd0 : 2'd2;
               end
               op_stw: begin
                  ctrl.src    = src_r2;
                  ctrl.mem_we = 1'b1;
               end
               default: ;
            endcase
         end
         st_exec3: begin
            case (ir)
               op_sw01, op_sw12, op_sw23: begin
                  ctrl.src    = src_alu;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = swap_lo;
               end
               op_pushc: begin
                  // pc already points past the pushc.
                  ctrl.src    = src_pc_dec;
                  ctrl.mem_we = 1'b1;
               end
               op_push: begin
                  ctrl.src    = src_r2;
                  ctrl.mem_we = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   state_legal: assert property (@(posedge clk) disable iff (!nRst)
      state inside {st_boot0, st_boot1, st_boot2, st_boot3, st_boot4,
                    st_fetch, st_decode, st_exec1, st_exec2, st_exec3});

endmodule

// ==== source/up_core.sv ====
module up_core (
   input  logic                  clk,
   input  logic                  nRst,
   output up_isa_pkg::mem_req_t  mem_req,
   input  up_isa_pkg::word_t     mem_rdata
);
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;

   ctrl_t       ctrl;
   word_t [3:0] regs;
   word_t       result;
   logic        regs_eq;
   logic        pc_lsb;

   up_control u_control (
      .clk       (clk),
      .nRst      (nRst),
      .regs_eq   (regs_eq),
      .pc_lsb    (pc_lsb),
      .mem_rdata (mem_rdata),
      .ctrl      (ctrl)
   );

   up_datapath u_datapath (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .regs      (regs),
      .mem_rdata (mem_rdata),
      .result    (result),
      .pc_lsb    (pc_lsb),
      .mem_req   (mem_req)
   );

   up_regfile u_regfile (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .result    (result),
      .mem_rdata (mem_rdata),
      .regs      (regs),
      .regs_eq   (regs_eq)
   );

endmodule

// ==== source/up_ctrl_pkg.sv ====
package up_ctrl_pkg;

   typedef enum logic [3:0] {
      st_boot0  = 4'h0,
      st_boot1  = 4'h1,
      st_boot2  = 4'h2,
      st_boot3  = 4'h3,
      st_boot4  = 4'h4,
      st_fetch  = 4'h5,
      st_decode = 4'h6,
      st_exec1  = 4'h7,
      st_exec2  = 4'h8,
      st_exec3  = 4'h9
   } state_e;

   // what drives the result bus.
   typedef enum logic [3:0] {
      src_boot_addr,
      src_fetch_addr,
      src_pc_inc,
      src_alu,
      src_r2,
      src_r3,
      src_sp,
      src_sp_inc,
      src_sp_dec,
      src_pc_dec,
      src_mem,
      src_zero
   } src_e;

   // first four line up with the arithmetic opcodes.
   typedef enum logic [2:0] {
      alu_add  = 3'd0,
      alu_sub  = 3'd1,
      alu_mul  = 3'd2,
      alu_nand = 3'd3,
      alu_xor  = 3'd4
   } alu_op_e;

   typedef logic [1:0] rsel_t;

   typedef struct packed {
      src_e    src;
      alu_op_e alu_op;
      rsel_t   alu_a;
      rsel_t   alu_b;
      logic    ir_we;
      logic    pc_we;
      logic    sp_we;
      logic    rb_we;
      rsel_t   rb_sel;
      logic    rb_from_mem;
      logic    ale;
      logic    mem_we;
   } ctrl_t;

endpackage

// ==== source/up_datapath.sv ====
module up_datapath (
   input  logic                     clk,
   input  logic                     nRst,
   input  up_ctrl_pkg::ctrl_t       ctrl,
   input  up_isa_pkg::word_t [3:0]  regs,
   input  up_isa_pkg::word_t        mem_rdata,
   output up_isa_pkg::word_t        result,
   output logic                     pc_lsb,
   output up_isa_pkg::mem_req_t     mem_req
);
   import up_isa_pkg::*;
   import up_ctrl_pkg::*;

   word_t pc;
   word_t sp;
   word_t addr;
   word_t alu_y;

   up_alu u_alu (
      .op (ctrl.alu_op),
      .a  (regs[ctrl.alu_a]),
      .b  (regs[ctrl.alu_b]),
      .y  (alu_y)
   );

   always_comb begin
      case (ctrl.src)
         // boot walks the address latch from 0 to 3.
         src_boot_addr:  result = addr + 8'd1;
         src_fetch_addr: result = {1'b0, pc[7:1]};
         src_pc_inc:     result = pc + 8'd1;
         src_alu:        result = alu_y;
         src_r2:         result = regs[2];
         src_r3:         result = regs[3];
         src_sp:         result = sp;
         src_sp_inc:     result = sp + 8'd1;
         src_sp_dec:     result = sp - 8'd1;
         src_pc_dec:     result = pc - 8'd1;
         src_mem:        result = mem_rdata;
         default:        result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc   <= PC_RESET;
         sp   <= SP_RESET;
         addr <= '0;
      end else begin
         if (ctrl.pc_we)
            pc <= result;
         if (ctrl.sp_we)
            sp <= result;
         if (ctrl.ale)
            addr <= result;
      end
   end

   assign pc_lsb  = pc[0];
   assign mem_req = '{addr: addr, wdata: result, we: ctrl.mem_we};

   // the latch and the write share the result bus.
   ale_we_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.ale && ctrl.mem_we));

endmodule

// ==== source/up_isa_pkg.sv ====
package up_isa_pkg;

   typedef logic [7:0] word_t;
   typedef logic [3:0] nibble_t;

   // two opcodes per memory byte, high nibble first.
   typedef enum nibble_t {
      op_add   = 4'h0,
      op_sub   = 4'h1,
      op_mul   = 4'h2,
      op_nand  = 4'h3,
      op_sw01  = 4'h4,
      op_sw12  = 4'h5,
      op_sw23  = 4'h6,
      op_be    = 4'h7,
      op_popc  = 4'h8,
      op_pushc = 4'h9,
      op_pop   = 4'hA,
      op_push  = 4'hB,
      op_ldw   = 4'hC,
      op_stw   = 4'hD,
      op_ref   = 4'hE,
      op_int   = 4'hF
   } opcode_e;

   // pc counts nibbles, sp counts bytes.
   localparam word_t PC_RESET  = 8'h08;
   localparam word_t SP_RESET  = 8'hFF;
   localparam int    MEM_WORDS = 256;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  we;
   } mem_req_t;

endpackage

// ==== source/up_regfile.sv ====
module up_regfile (
   input  logic                     clk,
   input  logic                     nRst,
   input  up_ctrl_pkg::ctrl_t       ctrl,
   input  up_isa_pkg::word_t        result,
   input  up_isa_pkg::word_t        mem_rdata,
   output up_isa_pkg::word_t [3:0]  regs,
   output logic                     regs_eq
);
   import up_isa_pkg::*;

   word_t wdata;

   // loads bypass the result bus.
   assign wdata = ctrl.rb_from_mem ? mem_rdata : result;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs <= '0;
      end else if (ctrl.rb_we) begin
         regs[ctrl.rb_sel] <= wdata;
      end
   end

   // branch condition for be.
   assign regs_eq = (regs[1] == regs[2]);

   load_has_we: assert property (@(posedge clk) disable iff (!nRst)
      ctrl.rb_from_mem |-> ctrl.rb_we);

endmodule

// ==== test/up_ref_model.svh ====
`ifndef UP_REF_MODEL_SVH
`define UP_REF_MODEL_SVH

// one memory write as seen on the bus.
typedef struct packed {
   word_t addr;
   word_t data;
} wr_t;

typedef wr_t wr_q_t [$];

// runs budget instructions after boot and lists the writes in order.
function automatic wr_q_t ref_writes(input word_t image [MEM_WORDS], input int budget);
   word_t   m [MEM_WORDS];
   word_t   r [4];
   word_t   pc;
   word_t   sp;
   word_t   t;
   opcode_e op;
   wr_q_t   q;
   m = image;
   for (int i = 0; i < 4; i++)
      r[i] = m[i];
   pc = PC_RESET;
   sp = SP_RESET;
   for (int n = 0; n < budget; n++) begin
      // even nibble address is the high half.
      t  = m[pc >> 1];
      op = opcode_e'(pc[0] ? t[3:0] : t[7:4]);
      pc = pc + 8'd1;
      case (op)
         op_add:  r[0] = r[1] + r[2];
         op_sub:  r[0] = r[1] - r[2];
         op_mul:  r[0] = r[1] * r[2];
         op_nand: r[0] = ~(r[1] & r[2]);
         op_sw01, op_sw12, op_sw23: begin
            t                = r[op[1:0]];
            r[op[1:0]]       = r[op[1:0] + 1];
            r[op[1:0] + 1]   = t;
         end
         op_be: begin
            if (r[1] == r[2])
               pc = r[3];
         end
         op_popc: begin
            sp = sp + 8'd1;
            pc = m[sp];
         end
         op_pushc: begin
            t     = pc - 8'd1;
            m[sp] = t;
            q.push_back('{addr: sp, data: t});
            sp    = sp - 8'd1;
         end
         op_pop: begin
            sp   = sp + 8'd1;
            r[2] = m[sp];
         end
         op_push: begin
            m[sp] = r[2];
            q.push_back('{addr: sp, data: r[2]});
            sp    = sp - 8'd1;
         end
         op_ldw: r[2] = m[r[3]];
         op_stw: begin
            m[r[3]] = r[2];
            q.push_back('{addr: r[3], data: r[2]});
         end
         op_ref:  r[0] = m[0];
         default: ;
      endcase
   end
   return q;
endfunction

`endif

// ==== test/up_core_tb.sv ====
module up_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import up_isa_pkg::*;

   `include "up_ref_model.svh"

   localparam int CLK_PERIOD     = 10;
   localparam int N_RANDOM       = 20;
   localparam int RANDOM_BUDGET  = 40;
   localparam int DIRECTED_INSNS = 16 + 10 + 15 + 16;
   localparam int N_TESTS        = 4 + N_RANDOM;
   localparam int TOTAL_INSNS    = DIRECTED_INSNS + N_RANDOM * RANDOM_BUDGET;
   localparam int WATCHDOG_NS    = (5 * TOTAL_INSNS + 10 * N_TESTS) * CLK_PERIOD;

   logic     clk = 1'b0;
   logic     nRst = 1'b0;
   mem_req_t mem_req;
   word_t    mem_rdata;
   word_t    mem [MEM_WORDS] = '{default: '0};
   word_t    image [MEM_WORDS];
   logic     load = 1'b0;
   logic     active = 1'b0;
   wr_q_t    exp_q;
   int       n_seen;
   int       err_count;
   int       tests_run;
   int       tests_failed;
   string    cur_name = "";

   up_core u_up_core (
      .clk       (clk),
      .nRst      (nRst),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // image copy happens during reset.
   always @(posedge clk) begin
      if (load)
         mem <= image;
      else if (mem_req.we)
         mem[mem_req.addr] <= mem_req.wdata;
   end

   assign mem_rdata = mem[mem_req.addr];

   task automatic check_value(input string name, input wr_t expected, input wr_t actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected addr %h data %h, actual addr %h data %h",
                  name, expected.addr, expected.data, actual.addr, actual.data);
         err_count++;
      end
   endtask

   always @(posedge clk) begin : compare
      wr_t got;
      if (active && mem_req.we) begin
         got = '{addr: mem_req.addr, data: mem_req.wdata};
         check_value(cur_name, exp_q[n_seen], got);
         n_seen++;
      end
   end

   // registers in bytes 0 to 3, code packed from nibble 8 on.
   task automatic build_image(input word_t r0, input word_t r1, input word_t r2,
                              input word_t r3, input logic [63:0] code, input int n_nib);
      int       idx;
      logic [3:0] nib;
      for (int a = 0; a < MEM_WORDS; a++)
         image[a] = 8'hA5 ^ word_t'(a);
      image[0] = r0;
      image[1] = r1;
      image[2] = r2;
      image[3] = r3;
      for (int i = 0; i < n_nib; i++) begin
         nib = code[4 * (n_nib - 1 - i) +: 4];
         idx = 4 + i / 2;
         if (i % 2 == 0)
            image[idx][7:4] = nib;
         else
            image[idx][3:0] = nib;
      end
   endtask

   task automatic random_image();
      for (int a = 0; a < MEM_WORDS; a++)
         image[a] = word_t'($urandom);
   endtask

   task automatic run_test(input string name, input int budget);
      int errs_before;
      errs_before = err_count;
      exp_q       = ref_writes(image, budget);
      cur_name    = name;
      n_seen      = 0;
      @(negedge clk);
      nRst = 1'b0;
      load = 1'b1;
      repeat (3) @(negedge clk);
      load   = 1'b0;
      nRst   = 1'b1;
      active = 1'b1;
      while (n_seen < exp_q.size())
         @(negedge clk);
      active = 1'b0;
      tests_run++;
      if (err_count == errs_before) begin
         $display("%-10s ok      %0d writes", name, exp_q.size());
      end else begin
         $display("%-10s FAILED  %0d mismatches", name, err_count - errs_before);
         tests_failed++;
      end
   endtask

   initial begin : main
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(32'hf76d_bef0));
      build_image(8'h00, 8'h37, 8'h5c, 8'h80, 64'h045d_145d_245d_345d, 16);
      run_test("alu", 16);
      build_image(8'h11, 8'h22, 8'h33, 8'h90, 64'h4b_5b6d_5d4b, 10);
      run_test("swaps", 10);
      // be at nibble 8 jumps over the stw at nibble 9.
      build_image(8'h42, 8'h10, 8'h10, 8'h0a, 64'h7d67_d6c5_65d0_e45d, 16);
      run_test("branch", 15);
      // pushc at nibble 12, popc loops back to it.
      build_image(8'h01, 8'h02, 8'hc3, 8'h20, 64'hb5ad_96d8, 8);
      run_test("stack", 16);
      for (int i = 0; i < N_RANDOM; i++) begin
         random_image();
         run_test($sformatf("random_%0d", i), RANDOM_BUDGET);
      end
      $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
               err_count);
      if (err_count == 0 && tests_failed == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: test %s never produced all of its expected writes", cur_name);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== up_core.f ====
+incdir+test
source/up_isa_pkg.sv
source/up_ctrl_pkg.sv
source/up_alu.sv
source/up_regfile.sv
source/up_datapath.sv
source/up_control.sv
source/up_core.sv
test/up_core_tb.sv
